/* lsu_pkg.sv */
// ---------------------------------------
// Load/store unit package
//   Data, address and tag widths
//   Load and store queue depths
//   Shared word typedefs
//   Memory arbiter grant encoding
// ---------------------------------------

package lsu_pkg;

    // Datapath widths
    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int TAG_W  = 6;

    // Queue depths, both must be powers of two so pointers wrap on their own
    localparam int LQ_DEPTH = 4;
    localparam int SQ_DEPTH = 4;

    // Queue pointer widths
    localparam int LQ_IDX_W = $clog2(LQ_DEPTH);
    localparam int SQ_IDX_W = $clog2(SQ_DEPTH);

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [TAG_W-1:0]  tag_t;

    // Winner of the shared memory port in one cycle
    typedef enum logic [1:0] {
        GNT_NONE  = 2'd0,
        GNT_STORE = 2'd1,
        GNT_LOAD  = 2'd2
    } grant_e;

endpackage

/* lsq_if.sv */
// ---------------------------------------
// Load queue to store queue link
//   Forwarding lookup for the oldest load
//   Load ordering status for store commit
// ---------------------------------------

interface lsq_if
    import lsu_pkg::*;
();

    // Forwarding lookup, answered in the same cycle
    addr_t fwd_addr;
    tag_t  fwd_tag;
    logic  fwd_hit;
    data_t fwd_data;

    // Any load queued, and the tag of the oldest one
    logic  ld_pending;
    tag_t  ld_oldest_tag;

    modport lq (
        output fwd_addr,
        output fwd_tag,
        output ld_pending,
        output ld_oldest_tag,
        input  fwd_hit,
        input  fwd_data
    );

    modport sq (
        input  fwd_addr,
        input  fwd_tag,
        input  ld_pending,
        input  ld_oldest_tag,
        output fwd_hit,
        output fwd_data
    );

endinterface

/* mem_req_if.sv */
// ---------------------------------------
// Queue to memory arbiter request link
//   Request held until granted
//   Read data valid in the grant cycle
// ---------------------------------------

interface mem_req_if
    import lsu_pkg::*;
();

    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
    logic  gnt;
    data_t rdata;

    modport client (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata
    );

endinterface

/* load_queue.sv */
// ---------------------------------------
// Load queue
//   Circular buffer of load address and tag
//   Forwarding lookup for the head load
//   Memory read request on a forward miss
//   Registered load result
// ---------------------------------------

module load_queue
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      disp_valid_i,
    input  logic      disp_store_i,
    input  addr_t     disp_addr_i,
    input  tag_t      disp_tag_i,
    lsq_if.lq         lq,
    mem_req_if.client mem,
    output logic      lq_full_o,
    output logic      ld_valid_o,
    output tag_t      ld_tag_o,
    output data_t     ld_data_o
);

    // Entry storage, payload only
    addr_t lq_addr [LQ_DEPTH];
    tag_t  lq_tag  [LQ_DEPTH];

    logic [LQ_DEPTH-1:0] lq_valid;
    logic [LQ_IDX_W-1:0] lq_head;
    logic [LQ_IDX_W-1:0] lq_tail;

    logic ld_push;
    logic ld_pop;
    logic head_valid;

    assign ld_push    = disp_valid_i && !disp_store_i;
    assign head_valid = lq_valid[lq_head];
    assign lq_full_o  = lq_valid[lq_tail];

    // ---------------------------------------
    // Head load service
    // ---------------------------------------

    // The head is always the oldest load, so it is also the lookup key
    assign lq.fwd_addr      = lq_addr[lq_head];
    assign lq.fwd_tag       = lq_tag[lq_head];
    assign lq.ld_pending    = |lq_valid;
    assign lq.ld_oldest_tag = lq_tag[lq_head];

    // Go to memory only when no older store can supply the data
    assign mem.req   = head_valid && !lq.fwd_hit;
    assign mem.we    = 1'b0;
    assign mem.addr  = lq_addr[lq_head];
    assign mem.wdata = '0;

    assign ld_pop = head_valid && (lq.fwd_hit || mem.gnt);

    // ---------------------------------------
    // Pointers and valid bits
    // ---------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lq_valid <= '0;
            lq_head  <= '0;
            lq_tail  <= '0;
        end else begin
            if (ld_push) begin
                lq_valid[lq_tail] <= 1'b1;
                lq_tail           <= lq_tail + 1'b1;
            end
            if (ld_pop) begin
                lq_valid[lq_head] <= 1'b0;
                lq_head           <= lq_head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_push) begin
            lq_addr[lq_tail] <= disp_addr_i;
            lq_tag[lq_tail]  <= disp_tag_i;
        end
    end

    // Result register, one load answered per cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ld_valid_o <= 1'b0;
        end else begin
            ld_valid_o <= ld_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_pop) begin
            ld_tag_o  <= lq_tag[lq_head];
            ld_data_o <= lq.fwd_hit ? lq.fwd_data : mem.rdata;
        end
    end

    // Dispatch must not target a full load queue
    a_no_load_overflow: assert property (
        @(posedge clk) disable iff (!rst)
        ld_push |-> !lq_full_o
    );

endmodule

/* store_queue.sv */
// ---------------------------------------
// Store queue
//   Circular buffer of store entries
//   Youngest older store forwarding match
//   Commit check against ROB head and loads
//   Store acknowledge at enqueue
// ---------------------------------------

module store_queue
    import lsu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      disp_valid_i,
    input  logic      disp_store_i,
    input  addr_t     disp_addr_i,
    input  data_t     disp_data_i,
    input  tag_t      disp_tag_i,
    input  tag_t      rob_head_i,
    lsq_if.sq         sq,
    mem_req_if.client mem,
    output logic      sq_full_o,
    output logic      st_ack_o,
    output tag_t      st_ack_tag_o
);

    addr_t sq_addr [SQ_DEPTH];
    data_t sq_data [SQ_DEPTH];
    tag_t  sq_tag  [SQ_DEPTH];

    logic [SQ_DEPTH-1:0] sq_valid;
    logic [SQ_IDX_W-1:0] sq_head;
    logic [SQ_IDX_W-1:0] sq_tail;

    logic st_push;
    logic st_pop;
    logic head_valid;
    logic older_load;
    tag_t fwd_best_tag;

    assign st_push    = disp_valid_i && disp_store_i;
    assign head_valid = sq_valid[sq_head];
    assign sq_full_o  = sq_valid[sq_tail];

    // ---------------------------------------
    // Forwarding search
    // ---------------------------------------

    // Among older stores to the load's address, keep the one with the largest tag
    always_comb begin
        sq.fwd_hit   = 1'b0;
        sq.fwd_data  = '0;
        fwd_best_tag = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (sq_valid[i] && (sq_tag[i] < sq.fwd_tag) && (sq_addr[i] == sq.fwd_addr)) begin
                if (!sq.fwd_hit || (sq_tag[i] > fwd_best_tag)) begin
                    sq.fwd_hit   = 1'b1;
                    sq.fwd_data  = sq_data[i];
                    fwd_best_tag = sq_tag[i];
                end
            end
        end
    end

    // ---------------------------------------
    // Commit and write
    // ---------------------------------------

    // An unanswered older load must read memory before this store lands
    assign older_load = sq.ld_pending && (sq.ld_oldest_tag < sq_tag[sq_head]);

    assign mem.req   = head_valid && (sq_tag[sq_head] == rob_head_i) && !older_load;
    assign mem.we    = 1'b1;
    assign mem.addr  = sq_addr[sq_head];
    assign mem.wdata = sq_data[sq_head];

    assign st_pop = mem.req && mem.gnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sq_valid <= '0;
            sq_head  <= '0;
            sq_tail  <= '0;
            st_ack_o <= 1'b0;
        end else begin
            st_ack_o <= st_push;
            if (st_push) begin
                sq_valid[sq_tail] <= 1'b1;
                sq_tail           <= sq_tail + 1'b1;
            end
            if (st_pop) begin
                sq_valid[sq_head] <= 1'b0;
                sq_head           <= sq_head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (st_push) begin
            sq_addr[sq_tail] <= disp_addr_i;
            sq_data[sq_tail] <= disp_data_i;
            sq_tag[sq_tail]  <= disp_tag_i;
            st_ack_tag_o     <= disp_tag_i;
        end
    end

    a_no_store_overflow: assert property (
        @(posedge clk) disable iff (!rst)
        st_push |-> !sq_full_o
    );

    // Load queue status and store write must agree on program order
    a_store_after_older_loads: assert property (
        @(posedge clk) disable iff (!rst)
        mem.req |-> !(sq.ld_pending && (sq.ld_oldest_tag < sq_tag[sq_head]))
    );

endmodule

/* mem_arbiter.sv */
// ---------------------------------------
// Memory port arbiter
//   Store over load priority
//   External port mux and read return
// ---------------------------------------

module mem_arbiter
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    mem_req_if.arbiter  st,
    mem_req_if.arbiter  ld,
    output logic        mem_req_o,
    output logic        mem_we_o,
    output addr_t       mem_addr_o,
    output data_t       mem_wdata_o,
    input  data_t       mem_rdata_i
);

    grant_e gnt_sel;

    // A committing store frees a ROB slot, so it goes first
    always_comb begin
        if (st.req) begin
            gnt_sel = GNT_STORE;
        end else if (ld.req) begin
            gnt_sel = GNT_LOAD;
        end else begin
            gnt_sel = GNT_NONE;
        end
    end

    assign st.gnt = (gnt_sel == GNT_STORE);
    assign ld.gnt = (gnt_sel == GNT_LOAD);

    assign mem_req_o   = (gnt_sel != GNT_NONE);
    assign mem_we_o    = st.gnt ? st.we : ld.we;
    assign mem_addr_o  = st.gnt ? st.addr : ld.addr;
    assign mem_wdata_o = st.gnt ? st.wdata : ld.wdata;

    // Combinational read, returned to both sides
    assign st.rdata = mem_rdata_i;
    assign ld.rdata = mem_rdata_i;

    a_one_grant: assert property (
        @(posedge clk) disable iff (!rst)
        !(st.gnt && ld.gnt)
    );

    // Load side holds its request while stores win
    a_load_req_held: assert property (
        @(posedge clk) disable iff (!rst)
        (ld.req && !ld.gnt) |=> ld.req
    );

endmodule

/* lsu_top.sv */
// ---------------------------------------
// Load/store unit top level
//   Load queue, store queue, memory arbiter
//   Plain ports to interface wiring
// ---------------------------------------

module lsu_top
    import lsu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // Dispatch, one operation per cycle
    input  logic  disp_valid_i,
    input  logic  disp_store_i,
    input  addr_t disp_addr_i,
    input  data_t disp_data_i,
    input  tag_t  disp_tag_i,

    input  tag_t  rob_head_i,

    output logic  lq_full_o,
    output logic  sq_full_o,

    output logic  st_ack_o,
    output tag_t  st_ack_tag_o,

    output logic  ld_valid_o,
    output tag_t  ld_tag_o,
    output data_t ld_data_o,

    // Data memory port
    output logic  mem_req_o,
    output logic  mem_we_o,
    output addr_t mem_addr_o,
    output data_t mem_wdata_o,
    input  data_t mem_rdata_i
);

    lsq_if     lsq_bus ();
    mem_req_if st_mem ();
    mem_req_if ld_mem ();

    load_queue i_load_queue (
        .clk          (clk),
        .rst          (rst),
        .disp_valid_i (disp_valid_i),
        .disp_store_i (disp_store_i),
        .disp_addr_i  (disp_addr_i),
        .disp_tag_i   (disp_tag_i),
        .lq           (lsq_bus.lq),
        .mem          (ld_mem.client),
        .lq_full_o    (lq_full_o),
        .ld_valid_o   (ld_valid_o),
        .ld_tag_o     (ld_tag_o),
        .ld_data_o    (ld_data_o)
    );

    store_queue i_store_queue (
        .clk          (clk),
        .rst          (rst),
        .disp_valid_i (disp_valid_i),
        .disp_store_i (disp_store_i),
        .disp_addr_i  (disp_addr_i),
        .disp_data_i  (disp_data_i),
        .disp_tag_i   (disp_tag_i),
        .rob_head_i   (rob_head_i),
        .sq           (lsq_bus.sq),
        .mem          (st_mem.client),
        .sq_full_o    (sq_full_o),
        .st_ack_o     (st_ack_o),
        .st_ack_tag_o (st_ack_tag_o)
    );

    mem_arbiter i_mem_arbiter (
        .clk         (clk),
        .rst         (rst),
        .st          (st_mem.arbiter),
        .ld          (ld_mem.arbiter),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

/* tb_lsu.sv */
// ---------------------------------------
// Load/store unit testbench
//   Word memory model on the data port
//   Program-order reference for load data
//   Directed and random dispatch sequences
//   Output checker and watchdog
// ---------------------------------------

module tb_lsu
    import lsu_pkg::*;
();

    localparam int   CLK_PERIOD = 40;
    localparam int   DRIVE_DLY  = 2;
    localparam int   MEM_WORDS  = 64;
    localparam int   TAG_SPACE  = 1 << TAG_W;
    localparam int   N_RAND     = 32;
    // Operations issued before the random phase
    localparam int   N_DIRECTED = 14;
    localparam int   N_OPS      = N_DIRECTED + N_RAND;
    localparam tag_t PARK_TAG   = 6'h3f;

    logic  clk = 1'b0;
    logic  rst;
    logic  disp_valid_i;
    logic  disp_store_i;
    addr_t disp_addr_i;
    data_t disp_data_i;
    tag_t  disp_tag_i;
    tag_t  rob_head_i;
    logic  lq_full_o;
    logic  sq_full_o;
    logic  st_ack_o;
    tag_t  st_ack_tag_o;
    logic  ld_valid_o;
    tag_t  ld_tag_o;
    data_t ld_data_o;
    logic  mem_req_o;
    logic  mem_we_o;
    addr_t mem_addr_o;
    data_t mem_wdata_o;
    data_t mem_rdata_i;

    // Program order record, indexed by tag
    bit    op_store [TAG_SPACE];
    int    op_widx  [TAG_SPACE];
    data_t op_data  [TAG_SPACE];
    bit    done     [TAG_SPACE];
    int    next_tag = 0;
    int    next_ld  = 0;
    bit    auto_rob = 1'b0;

    data_t mem_model [MEM_WORDS];
    logic  ack_due;
    tag_t  ack_due_tag;
    int    ld_errs  = 0;
    int    ack_errs = 0;
    int    mem_errs = 0;
    int    seq_errs = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    lsu_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .disp_valid_i (disp_valid_i),
        .disp_store_i (disp_store_i),
        .disp_addr_i  (disp_addr_i),
        .disp_data_i  (disp_data_i),
        .disp_tag_i   (disp_tag_i),
        .rob_head_i   (rob_head_i),
        .lq_full_o    (lq_full_o),
        .sq_full_o    (sq_full_o),
        .st_ack_o     (st_ack_o),
        .st_ack_tag_o (st_ack_tag_o),
        .ld_valid_o   (ld_valid_o),
        .ld_tag_o     (ld_tag_o),
        .ld_data_o    (ld_data_o),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_rdata_i  (mem_rdata_i)
    );

    function automatic data_t init_word(input int widx);
        return 32'hc3a5_0000 ^ (widx * 32'h0001_0203);
    endfunction

    function automatic addr_t word_addr(input int widx);
        return addr_t'(widx * 4);
    endfunction

    // Youngest store to the word that is older than tag, else the initial word
    function automatic data_t expected_word(input int widx, input int tag);
        for (int t = tag - 1; t >= 0; t--) begin
            if (op_store[t] && op_widx[t] == widx) begin
                return op_data[t];
            end
        end
        return init_word(widx);
    endfunction

    function automatic int oldest_open();
        for (int t = 0; t < next_tag; t++) begin
            if (!done[t]) begin
                return t;
            end
        end
        return next_tag;
    endfunction

    // ---------------------------------------
    // Memory model, read is combinational
    // ---------------------------------------
    assign mem_rdata_i = mem_model[mem_addr_o[7:2]];

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_model[i] <= init_word(i);
            end
        end else if (mem_req_o && mem_we_o) begin
            mem_model[mem_addr_o[7:2]] <= mem_wdata_o;
        end
    end

    // A store taken at this edge is acknowledged in the next cycle
    always @(posedge clk) begin
        ack_due     <= rst && disp_valid_i && disp_store_i;
        ack_due_tag <= disp_tag_i;
    end

    // ---------------------------------------
    // Checker, samples registered outputs mid-cycle
    // ---------------------------------------
    always @(negedge clk) begin : check_outputs
        int t;
        if (rst) begin
            assert (st_ack_o == ack_due) else begin
                ack_errs++;
                $display("[ERROR] %0t st_ack_o is %0b, expected %0b", $time, st_ack_o, ack_due);
            end
            if (ack_due) begin
                assert (st_ack_tag_o == ack_due_tag) else begin
                    ack_errs++;
                    $display("[ERROR] %0t ack tag %0d, expected %0d",
                             $time, st_ack_tag_o, ack_due_tag);
                end
            end
            if (ld_valid_o) begin
                while (next_ld < next_tag && op_store[next_ld]) begin
                    next_ld++;
                end
                assert (next_ld < next_tag) else begin
                    ld_errs++;
                    $display("Load result for tag %0d arrived with no load outstanding", ld_tag_o);
                end
                if (next_ld < next_tag) begin
                    assert (ld_tag_o == tag_t'(next_ld)) else begin
                        ld_errs++;
                        $display("[ERROR] %0t load tag %0d, expected %0d", $time, ld_tag_o, next_ld);
                    end
                    assert (ld_data_o == expected_word(op_widx[next_ld], next_ld)) else begin
                        ld_errs++;
                        $display("[ERROR] %0t load %0d data %h, expected %h", $time, next_ld,
                                 ld_data_o, expected_word(op_widx[next_ld], next_ld));
                    end
                    done[next_ld] = 1'b1;
                    next_ld++;
                end
            end
            if (mem_req_o && mem_we_o) begin
                t = int'(rob_head_i);
                assert (t < next_tag && op_store[t] && !done[t]
                        && mem_addr_o == word_addr(op_widx[t]) && mem_wdata_o == op_data[t])
                else begin
                    mem_errs++;
                    $display("[ERROR] %0t write %h to %h does not match ROB head %0d",
                             $time, mem_wdata_o, mem_addr_o, t);
                end
                for (int j = 0; j < t && j < next_tag; j++) begin
                    assert (done[j]) else begin
                        mem_errs++;
                        $display("Store %0d written before older operation %0d finished", t, j);
                    end
                end
                done[t] = 1'b1;
            end
        end
    end

    // ---------------------------------------
    // Stimulus
    // ---------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
        if (auto_rob) begin
            rob_head_i = tag_t'(oldest_open());
        end
    endtask

    task automatic dispatch(input bit is_store, input int widx, input data_t data);
        while (is_store ? sq_full_o : lq_full_o) begin
            next_cycle();
        end
        op_store[next_tag] = is_store;
        op_widx[next_tag]  = widx;
        op_data[next_tag]  = data;
        disp_valid_i = 1'b1;
        disp_store_i = is_store;
        disp_addr_i  = word_addr(widx);
        disp_data_i  = data;
        disp_tag_i   = tag_t'(next_tag);
        next_tag++;
        next_cycle();
        disp_valid_i = 1'b0;
    endtask

    task automatic wait_done(input int tag);
        while (!done[tag]) begin
            next_cycle();
        end
    endtask

    // Stores fill their queue, then commit one per cycle while loads pile up
    task automatic fill_queues();
        int base;
        base = next_tag;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            dispatch(1'b1, 24 + i, $urandom());
        end
        assert (sq_full_o && !lq_full_o) else begin
            seq_errs++;
            $display("[ERROR] %0t sq_full_o %0b lq_full_o %0b after store fill",
                     $time, sq_full_o, lq_full_o);
        end
        for (int i = 0; i < LQ_DEPTH; i++) begin
            rob_head_i = tag_t'(base + i);
            dispatch(1'b0, 32 + i, '0);
        end
        assert (lq_full_o) else begin
            seq_errs++;
            $display("[ERROR] %0t lq_full_o low after load fill", $time);
        end
        rob_head_i = PARK_TAG;
        wait_done(next_tag - 1);
    endtask

    initial begin
        int total;
        void'($urandom(32'hd9aa_bfda));
        rst          = 1'b0;
        disp_valid_i = 1'b0;
        disp_store_i = 1'b0;
        disp_addr_i  = '0;
        disp_data_i  = '0;
        disp_tag_i   = '0;
        rob_head_i   = PARK_TAG;
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b1;
        next_cycle();

        assert (!ld_valid_o && !st_ack_o && !mem_req_o && !lq_full_o && !sq_full_o) else begin
            seq_errs++;
            $display("[ERROR] %0t outputs not idle after reset", $time);
        end

        // Lone load from the initial memory image
        dispatch(1'b0, 5, '0);
        wait_done(0);

        // Forward from a store that has not reached the ROB head
        dispatch(1'b1, 9, $urandom());
        dispatch(1'b0, 9, '0);
        wait_done(2);
        rob_head_i = tag_t'(1);
        wait_done(1);

        // An older store takes the port, so the load is still queued
        // when the ROB head already names the younger store
        dispatch(1'b1, 13, $urandom());
        dispatch(1'b0, 12, '0);
        rob_head_i = tag_t'(3);
        dispatch(1'b1, 12, $urandom());
        rob_head_i = tag_t'(5);
        wait_done(5);
        rob_head_i = PARK_TAG;

        fill_queues();

        // Random mix over 8 words, ROB head tracks the oldest open operation
        auto_rob = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            dispatch(bit'($urandom_range(1, 0)), 40 + int'($urandom_range(7, 0)), $urandom());
        end
        while (oldest_open() != next_tag) begin
            next_cycle();
        end

        for (int w = 0; w < MEM_WORDS; w++) begin
            assert (mem_model[w] == expected_word(w, next_tag)) else begin
                seq_errs++;
                $display("[ERROR] %0t memory word %0d is %h, expected %h",
                         $time, w, mem_model[w], expected_word(w, next_tag));
            end
        end

        total = ld_errs + ack_errs + mem_errs + seq_errs;
        $display("Errors: load %0d, ack %0d, write %0d, sequence %0d",
                 ld_errs, ack_errs, mem_errs, seq_errs);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Roughly 200 cycles for every operation issued
    initial begin
        #(N_OPS * 200 * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", N_OPS * 200);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* build.f */
lsu_pkg.sv
lsq_if.sv
mem_req_if.sv
load_queue.sv
store_queue.sv
mem_arbiter.sv
lsu_top.sv
tb_lsu.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= tb_lsu
RTL_TOP   ?= lsu_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
